// File: Bender.yml
package:
  name: lookup_engine

sources:
  - rtl/lookup_pkg.sv
  - rtl/ctrl_pkg.sv
  - rtl/tbl_wr_if.sv
  - rtl/ctrl_packet_parser.sv
  - rtl/match_tcam.sv
  - rtl/action_ram.sv
  - rtl/lookup_fsm.sv
  - rtl/lookup_engine_top.sv
  - target: simulation
    files:
      - sim/tb_lookup_engine.sv

// File: list.f
rtl/lookup_pkg.sv
rtl/ctrl_pkg.sv
rtl/tbl_wr_if.sv
rtl/ctrl_packet_parser.sv
rtl/match_tcam.sv
rtl/action_ram.sv
rtl/lookup_fsm.sv
rtl/lookup_engine_top.sv
sim/tb_lookup_engine.sv

// File: rtl/action_ram.sv
// action table, one write port and one registered read port
`timescale 1ns/1ps

module action_ram #(
    parameter int TABLE_DEPTH = lookup_pkg::TABLE_DEPTH_DEF
) (
    input  logic                           clk,
    input  logic                           rd_en,
    input  logic [$clog2(TABLE_DEPTH)-1:0] rd_index,
    output lookup_pkg::act_t               rd_action,
    tbl_wr_if.ram                          wr
);

    lookup_pkg::act_t mem [TABLE_DEPTH];

    always_ff @(posedge clk) begin
        if (wr.act_wr) begin
            mem[wr.index] <= wr.act_entry;
        end
    end

    // output holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_action <= mem[rd_index];
        end
    end

    rd_index_known: assert property (
        @(posedge clk) rd_en |-> !$isunknown(rd_index)
    );

endmodule

// File: rtl/ctrl_packet_parser.sv
// control stream parser: claims table writes, forwards all other packets
`timescale 1ns/1ps

module ctrl_packet_parser #(
    parameter int STAGE_ID  = 0,
    parameter int LOOKUP_ID = 2
) (
    input  logic            clk,
    input  logic            rst_n,
    input  ctrl_pkg::beat_t in_data,
    input  ctrl_pkg::user_t in_user,
    input  ctrl_pkg::keep_t in_keep,
    input  logic            in_valid,
    input  logic            in_last,
    output ctrl_pkg::beat_t out_data,
    output ctrl_pkg::user_t out_user,
    output ctrl_pkg::keep_t out_keep,
    output logic            out_valid,
    output logic            out_last,
    tbl_wr_if.parser        wr
);

    ctrl_pkg::ctrl_state_e state;
    ctrl_pkg::ctrl_state_e state_nxt;

    ctrl_pkg::beat_t first_data;
    ctrl_pkg::user_t first_user;
    ctrl_pkg::keep_t first_keep;

    ctrl_pkg::beat_t d_data;
    ctrl_pkg::user_t d_user;
    ctrl_pkg::keep_t d_keep;
    logic            d_valid;
    logic            d_last;

    ctrl_pkg::beat_t swapped;
    logic [7:0]      mod_id;
    logic            claimed;
    logic            emit_first;
    logic            store_first;

    // entry beats arrive little endian
    always_comb begin
        for (int b = 0; b < ctrl_pkg::KEEP_W; b++) begin
            swapped[8*b +: 8] = in_data[8*(ctrl_pkg::KEEP_W-1-b) +: 8];
        end
    end

    assign mod_id  = in_data[ctrl_pkg::MODID_LSB +: 8];
    assign claimed = mod_id[7:3] == 5'(STAGE_ID) && mod_id[2:0] == 3'(LOOKUP_ID)
                  && in_data[ctrl_pkg::FLAG_LSB +: 16] == ctrl_pkg::CTRL_FLAG;

    assign emit_first  = state == ctrl_pkg::C_PARSE && in_valid && !claimed;
    assign store_first = state_nxt == ctrl_pkg::C_PARSE && state != ctrl_pkg::C_PARSE;

    always_comb begin
        state_nxt = state;
        case (state)
            ctrl_pkg::C_IDLE: begin
                // single-beat packets go straight through the delay register
                if (in_valid) begin
                    state_nxt = in_last ? ctrl_pkg::C_FORWARD : ctrl_pkg::C_PARSE;
                end
            end
            ctrl_pkg::C_PARSE: begin
                if (in_valid) begin
                    if (!claimed) begin
                        state_nxt = ctrl_pkg::C_FORWARD;
                    end else if (in_last) begin
                        state_nxt = ctrl_pkg::C_IDLE;
                    end else if (in_data[ctrl_pkg::RESV_LSB +: 4] == 4'd0) begin
                        state_nxt = ctrl_pkg::C_CAM_ENTRY;
                    end else begin
                        state_nxt = ctrl_pkg::C_ACT_FIRST;
                    end
                end
            end
            ctrl_pkg::C_CAM_ENTRY, ctrl_pkg::C_ACT_LAST: begin
                if (in_valid) begin
                    state_nxt = in_last ? ctrl_pkg::C_IDLE : ctrl_pkg::C_DRAIN;
                end
            end
            ctrl_pkg::C_ACT_FIRST: begin
                if (in_valid) begin
                    state_nxt = in_last ? ctrl_pkg::C_IDLE : ctrl_pkg::C_ACT_SECOND;
                end
            end
            ctrl_pkg::C_ACT_SECOND: begin
                if (in_valid) begin
                    state_nxt = in_last ? ctrl_pkg::C_IDLE : ctrl_pkg::C_ACT_LAST;
                end
            end
            ctrl_pkg::C_DRAIN: begin
                if (in_valid && in_last) begin
                    state_nxt = ctrl_pkg::C_IDLE;
                end
            end
            ctrl_pkg::C_FORWARD: begin
                // next packet may start while the last beat leaves
                if (d_valid && d_last) begin
                    if (!in_valid) begin
                        state_nxt = ctrl_pkg::C_IDLE;
                    end else if (!in_last) begin
                        state_nxt = ctrl_pkg::C_PARSE;
                    end
                end
            end
            default: state_nxt = ctrl_pkg::C_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ctrl_pkg::C_IDLE;
            d_valid   <= 1'b0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            wr.cam_wr <= 1'b0;
            wr.act_wr <= 1'b0;
        end else begin
            state     <= state_nxt;
            d_valid   <= in_valid;
            out_valid <= emit_first || (state == ctrl_pkg::C_FORWARD && d_valid);
            out_last  <= state == ctrl_pkg::C_FORWARD && d_valid && d_last;
            wr.cam_wr <= state == ctrl_pkg::C_CAM_ENTRY && in_valid;
            wr.act_wr <= state == ctrl_pkg::C_ACT_LAST && in_valid;
        end
    end

    always_ff @(posedge clk) begin
        d_data <= in_data;
        d_user <= in_user;
        d_keep <= in_keep;
        d_last <= in_last;
        if (store_first) begin
            first_data <= in_data;
            first_user <= in_user;
            first_keep <= in_keep;
        end
        out_data <= emit_first ? first_data : d_data;
        out_user <= emit_first ? first_user : d_user;
        out_keep <= emit_first ? first_keep : d_keep;
        if (state == ctrl_pkg::C_PARSE && in_valid && claimed) begin
            wr.index <= in_data[ctrl_pkg::INDEX_LSB +: $bits(wr.index)];
        end
        // top entry bits lie beyond the beat and read as zero
        if (state == ctrl_pkg::C_CAM_ENTRY && in_valid) begin
            wr.cam_entry <= lookup_pkg::cmp_t'(swapped[ctrl_pkg::BEAT_W-1:ctrl_pkg::CAM_ENTRY_LSB]);
        end
        if (state == ctrl_pkg::C_ACT_FIRST && in_valid) begin
            wr.act_entry[ctrl_pkg::ACT_HI_LSB +: ctrl_pkg::BEAT_W] <= swapped;
        end
        if (state == ctrl_pkg::C_ACT_SECOND && in_valid) begin
            wr.act_entry[ctrl_pkg::ACT_MID_LSB +: ctrl_pkg::BEAT_W] <= swapped;
        end
        // low fragment fills everything below the middle part
        if (state == ctrl_pkg::C_ACT_LAST && in_valid) begin
            wr.act_entry[0 +: ctrl_pkg::ACT_MID_LSB] <=
                swapped[ctrl_pkg::ACT_LO_SRC_LSB +: ctrl_pkg::ACT_MID_LSB];
        end
    end

    wr_pulse_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(wr.cam_wr && wr.act_wr)
    );

endmodule

// File: rtl/ctrl_pkg.sv
// control beat widths, field offsets, control flag and parser FSM states
package ctrl_pkg;

    localparam int BEAT_W = 256;
    localparam int USER_W = 128;
    localparam int KEEP_W = BEAT_W / 8;

    // fields of the raw second beat
    localparam int          MODID_LSB = 112;
    localparam int          RESV_LSB  = 120;
    localparam int          FLAG_LSB  = 64;
    localparam int          INDEX_LSB = 128;
    localparam logic [15:0] CTRL_FLAG = 16'hf2f1;

    // positions in byte-reversed entry beats
    localparam int CAM_ENTRY_LSB  = 59;
    localparam int ACT_HI_LSB     = 369;
    localparam int ACT_MID_LSB    = 113;
    localparam int ACT_LO_SRC_LSB = 143;

    typedef logic [BEAT_W-1:0] beat_t;
    typedef logic [USER_W-1:0] user_t;
    typedef logic [KEEP_W-1:0] keep_t;

    typedef enum logic [2:0] {
        C_IDLE,
        C_PARSE,
        C_CAM_ENTRY,
        C_ACT_FIRST,
        C_ACT_SECOND,
        C_ACT_LAST,
        C_FORWARD,
        C_DRAIN
    } ctrl_state_e;

endpackage

// File: rtl/lookup_engine_top.sv
// match-action lookup stage top level
`timescale 1ns/1ps

module lookup_engine_top #(
    parameter int STAGE_ID    = 0,
    parameter int LOOKUP_ID   = 2,
    parameter int TABLE_DEPTH = lookup_pkg::TABLE_DEPTH_DEF
) (
    input  logic             clk,
    input  logic             rst_n,
    input  lookup_pkg::key_t extract_key,
    input  lookup_pkg::key_t extract_mask,
    input  logic             key_valid,
    input  lookup_pkg::phv_t phv_in,
    output lookup_pkg::act_t action,
    output logic             action_valid,
    output lookup_pkg::phv_t phv_out,
    input  ctrl_pkg::beat_t  ctrl_in_data,
    input  ctrl_pkg::user_t  ctrl_in_user,
    input  ctrl_pkg::keep_t  ctrl_in_keep,
    input  logic             ctrl_in_valid,
    input  logic             ctrl_in_last,
    output ctrl_pkg::beat_t  ctrl_out_data,
    output ctrl_pkg::user_t  ctrl_out_user,
    output ctrl_pkg::keep_t  ctrl_out_keep,
    output logic             ctrl_out_valid,
    output logic             ctrl_out_last
);

    lookup_pkg::cmp_t               cmp_word;
    lookup_pkg::cmp_t               cmp_mask;
    logic                           tcam_key_valid;
    logic                           hit;
    logic [$clog2(TABLE_DEPTH)-1:0] hit_index;
    logic                           ram_rd;
    lookup_pkg::act_t               rd_action;

    tbl_wr_if #(.TABLE_DEPTH(TABLE_DEPTH)) u_tbl_wr ();

    ctrl_packet_parser #(
        .STAGE_ID  (STAGE_ID),
        .LOOKUP_ID (LOOKUP_ID)
    ) u_parser (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (ctrl_in_data),
        .in_user   (ctrl_in_user),
        .in_keep   (ctrl_in_keep),
        .in_valid  (ctrl_in_valid),
        .in_last   (ctrl_in_last),
        .out_data  (ctrl_out_data),
        .out_user  (ctrl_out_user),
        .out_keep  (ctrl_out_keep),
        .out_valid (ctrl_out_valid),
        .out_last  (ctrl_out_last),
        .wr        (u_tbl_wr.parser)
    );

    match_tcam #(.TABLE_DEPTH(TABLE_DEPTH)) u_tcam (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmp_word  (cmp_word),
        .cmp_mask  (cmp_mask),
        .cmp_valid (tcam_key_valid),
        .hit       (hit),
        .hit_index (hit_index),
        .wr        (u_tbl_wr.cam)
    );

    action_ram #(.TABLE_DEPTH(TABLE_DEPTH)) u_action_ram (
        .clk       (clk),
        .rd_en     (ram_rd),
        .rd_index  (hit_index),
        .rd_action (rd_action),
        .wr        (u_tbl_wr.ram)
    );

    lookup_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .extract_key  (extract_key),
        .extract_mask (extract_mask),
        .key_valid    (key_valid),
        .phv_in       (phv_in),
        .hit          (hit),
        .rd_action    (rd_action),
        .cmp_word     (cmp_word),
        .cmp_mask     (cmp_mask),
        .cmp_valid    (tcam_key_valid),
        .ram_rd       (ram_rd),
        .action       (action),
        .action_valid (action_valid),
        .phv_out      (phv_out)
    );

endmodule

// File: rtl/lookup_fsm.sv
// lookup sequencer: builds compare word, picks hit or default action
`timescale 1ns/1ps

module lookup_fsm (
    input  logic             clk,
    input  logic             rst_n,
    input  lookup_pkg::key_t extract_key,
    input  lookup_pkg::key_t extract_mask,
    input  logic             key_valid,
    input  lookup_pkg::phv_t phv_in,
    input  logic             hit,
    input  lookup_pkg::act_t rd_action,
    output lookup_pkg::cmp_t cmp_word,
    output lookup_pkg::cmp_t cmp_mask,
    output logic             cmp_valid,
    output logic             ram_rd,
    output lookup_pkg::act_t action,
    output logic             action_valid,
    output lookup_pkg::phv_t phv_out
);

    lookup_pkg::lookup_state_e state;
    lookup_pkg::phv_t          phv_q;
    logic                      result_rdy;
    logic                      key_take;

    assign key_take   = state == lookup_pkg::LK_IDLE && key_valid;
    // match result is registered one cycle after cmp_valid
    assign result_rdy = state == lookup_pkg::LK_MATCH_WAIT && !cmp_valid;
    assign ram_rd     = result_rdy && hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= lookup_pkg::LK_IDLE;
            cmp_valid    <= 1'b0;
            action_valid <= 1'b0;
        end else begin
            cmp_valid    <= key_take;
            action_valid <= (result_rdy && !hit) || state == lookup_pkg::LK_TRANSMIT;
            case (state)
                lookup_pkg::LK_IDLE: begin
                    if (key_valid) state <= lookup_pkg::LK_MATCH_WAIT;
                end
                lookup_pkg::LK_MATCH_WAIT: begin
                    if (result_rdy) begin
                        state <= hit ? lookup_pkg::LK_READ_WAIT : lookup_pkg::LK_IDLE;
                    end
                end
                lookup_pkg::LK_READ_WAIT: state <= lookup_pkg::LK_TRANSMIT;
                default: state <= lookup_pkg::LK_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (key_take) begin
            // VLAN bits never masked
            cmp_word <= {phv_in[lookup_pkg::VLAN_LSB + 4 +: lookup_pkg::VLAN_TAG_W], extract_key};
            cmp_mask <= {{lookup_pkg::VLAN_TAG_W{1'b0}}, extract_mask};
            phv_q    <= phv_in;
        end
        if (result_rdy && !hit) begin
            action  <= lookup_pkg::DEFAULT_ACTION;
            phv_out <= phv_q;
        end
        if (state == lookup_pkg::LK_TRANSMIT) begin
            action  <= rd_action;
            phv_out <= phv_q;
        end
    end

    action_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) action_valid |=> !action_valid
    );

endmodule

// File: rtl/lookup_pkg.sv
// lookup widths, vector types, default action and lookup FSM states
package lookup_pkg;

    localparam int KEY_W           = 197;
    localparam int VLAN_TAG_W      = 4;
    localparam int CMP_W           = VLAN_TAG_W + KEY_W;
    localparam int PHV_W           = 1124;
    localparam int ACT_W           = 625;
    localparam int TABLE_DEPTH_DEF = 16;

    // 12-bit VLAN ID, bits 7..4 join the compare word
    localparam int VLAN_LSB = 129;

    typedef logic [KEY_W-1:0] key_t;
    typedef logic [CMP_W-1:0] cmp_t;
    typedef logic [PHV_W-1:0] phv_t;
    typedef logic [ACT_W-1:0] act_t;

    localparam act_t DEFAULT_ACTION = act_t'('h3f);

    typedef enum logic [1:0] {
        LK_IDLE,
        LK_MATCH_WAIT,
        LK_READ_WAIT,
        LK_TRANSMIT
    } lookup_state_e;

endpackage

// File: rtl/match_tcam.sv
// ternary match table with lowest-index priority and registered result
`timescale 1ns/1ps

module match_tcam #(
    parameter int TABLE_DEPTH = lookup_pkg::TABLE_DEPTH_DEF
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  lookup_pkg::cmp_t               cmp_word,
    input  lookup_pkg::cmp_t               cmp_mask,
    input  logic                           cmp_valid,
    output logic                           hit,
    output logic [$clog2(TABLE_DEPTH)-1:0] hit_index,
    tbl_wr_if.cam                          wr
);

    localparam int IDX_W = $clog2(TABLE_DEPTH);

    lookup_pkg::cmp_t       entry [TABLE_DEPTH];
    logic [TABLE_DEPTH-1:0] entry_vld;
    logic [TABLE_DEPTH-1:0] match_vec;
    logic [IDX_W-1:0]       first_idx;

    always_ff @(posedge clk) begin
        if (wr.cam_wr) begin
            entry[wr.index] <= wr.cam_entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_vld <= '0;
        end else if (wr.cam_wr) begin
            entry_vld[wr.index] <= 1'b1;
        end
    end

    // mask bit 1 means don't care
    always_comb begin
        first_idx = '0;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            match_vec[i] = entry_vld[i] && ((entry[i] ^ cmp_word) & ~cmp_mask) == '0;
        end
        for (int i = TABLE_DEPTH - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                first_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit <= 1'b0;
        end else if (cmp_valid) begin
            hit <= |match_vec;
        end
    end

    always_ff @(posedge clk) begin
        if (cmp_valid) begin
            hit_index <= first_idx;
        end
    end

endmodule

// File: rtl/tbl_wr_if.sv
// table write interface from the control parser to the CAM and action RAM
`timescale 1ns/1ps

interface tbl_wr_if #(
    parameter int TABLE_DEPTH = lookup_pkg::TABLE_DEPTH_DEF
);

    logic                           cam_wr;
    logic                           act_wr;
    logic [$clog2(TABLE_DEPTH)-1:0] index;
    lookup_pkg::cmp_t               cam_entry;
    lookup_pkg::act_t               act_entry;

    modport parser (output cam_wr, act_wr, index, cam_entry, act_entry);

    modport cam (input cam_wr, index, cam_entry);

    modport ram (input act_wr, index, act_entry);

endinterface

// File: sim/tb_lookup_engine.sv
// testbench for the lookup stage: stimulus, reference model, checkers and watchdog
`timescale 1ns/1ps

module tb_lookup_engine;

    localparam int CLK_PERIOD  = 40;
    localparam int STAGE_ID    = 0;
    localparam int LOOKUP_ID   = 2;
    localparam int DEPTH       = 16;
    localparam int NUM_TESTS   = 6;
    localparam int LOOKUP_WAIT = 12;

    typedef lookup_pkg::key_t key_t;
    typedef lookup_pkg::cmp_t cmp_t;
    typedef lookup_pkg::phv_t phv_t;
    typedef lookup_pkg::act_t act_t;
    typedef ctrl_pkg::beat_t  beat_t;
    typedef ctrl_pkg::user_t  user_t;
    typedef ctrl_pkg::keep_t  keep_t;
    typedef logic [1151:0]    wide_t;

    localparam act_t       DEF_ACT    = act_t'('h3f);
    localparam logic [7:0] CLAIM_MOD  = {5'(STAGE_ID), 3'(LOOKUP_ID)};
    // stored entries carry zero VLAN bits, they lie past the end of the beat
    localparam logic [3:0] STORE_VLAN = 4'h0;
    localparam int         FIT_W      = ctrl_pkg::BEAT_W - ctrl_pkg::CAM_ENTRY_LSB;

    logic  clk;
    logic  rst_n;
    key_t  extract_key;
    key_t  extract_mask;
    logic  key_valid;
    phv_t  phv_in;
    act_t  action;
    logic  action_valid;
    phv_t  phv_out;
    beat_t ctrl_in_data;
    user_t ctrl_in_user;
    keep_t ctrl_in_keep;
    logic  ctrl_in_valid;
    logic  ctrl_in_last;
    beat_t ctrl_out_data;
    user_t ctrl_out_user;
    keep_t ctrl_out_keep;
    logic  ctrl_out_valid;
    logic  ctrl_out_last;

    // model of the tables as written by the testbench
    cmp_t cam_model [DEPTH];
    logic cam_vld   [DEPTH];
    act_t act_model [DEPTH];
    key_t t_key     [DEPTH];
    phv_t t_phv     [DEPTH];
    int   idx_list  [3] = '{3, 7, 12};

    beat_t pkt_data [8];
    user_t pkt_user [8];
    keep_t pkt_keep [8];

    act_t  exp_act_q[$];
    phv_t  exp_phv_q[$];
    int    exp_lat_q[$];
    int    start_q[$];
    beat_t exp_data_q[$];
    user_t exp_user_q[$];
    keep_t exp_keep_q[$];
    logic  exp_last_q[$];

    integer seed;
    int     errors       = 0;
    int     errs_before  = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;
    int     ncount       = 0;

    lookup_engine_top #(
        .STAGE_ID    (STAGE_ID),
        .LOOKUP_ID   (LOOKUP_ID),
        .TABLE_DEPTH (DEPTH)
    ) u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .extract_key    (extract_key),
        .extract_mask   (extract_mask),
        .key_valid      (key_valid),
        .phv_in         (phv_in),
        .action         (action),
        .action_valid   (action_valid),
        .phv_out        (phv_out),
        .ctrl_in_data   (ctrl_in_data),
        .ctrl_in_user   (ctrl_in_user),
        .ctrl_in_keep   (ctrl_in_keep),
        .ctrl_in_valid  (ctrl_in_valid),
        .ctrl_in_last   (ctrl_in_last),
        .ctrl_out_data  (ctrl_out_data),
        .ctrl_out_user  (ctrl_out_user),
        .ctrl_out_keep  (ctrl_out_keep),
        .ctrl_out_valid (ctrl_out_valid),
        .ctrl_out_last  (ctrl_out_last)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // budget of 200 cycles per test plus reset
    initial begin : watchdog
        #((200 * NUM_TESTS + 5) * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", 200 * NUM_TESTS + 5);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic wide_t rand_wide();
        wide_t v;
        for (int i = 0; i < 1152; i += 32) begin
            v[i +: 32] = $random(seed);
        end
        return v;
    endfunction

    function automatic beat_t byte_rev(input beat_t x);
        beat_t r;
        for (int b = 0; b < ctrl_pkg::KEEP_W; b++) begin
            r[8*b +: 8] = x[8*(ctrl_pkg::KEEP_W-1-b) +: 8];
        end
        return r;
    endfunction

    function automatic phv_t with_vlan(input phv_t p, input logic [3:0] v);
        phv_t r;
        r = p;
        r[lookup_pkg::VLAN_LSB + 4 +: 4] = v;
        return r;
    endfunction

    function automatic beat_t make_header(input logic [7:0] mod, input logic [15:0] flag,
                                          input logic [3:0] resv, input int idx);
        beat_t h;
        h = beat_t'(rand_wide());
        h[ctrl_pkg::MODID_LSB +: 8] = mod;
        h[ctrl_pkg::FLAG_LSB +: 16] = flag;
        h[ctrl_pkg::RESV_LSB +: 4]  = resv;
        h[ctrl_pkg::INDEX_LSB +: 8] = 8'(idx);
        return h;
    endfunction

    // lowest matching index wins, VLAN bits always compared
    function automatic void ref_lookup(input key_t key, input key_t mask, input phv_t phv,
                                       output act_t act, output logic hit);
        cmp_t word;
        cmp_t care;
        word = {phv[lookup_pkg::VLAN_LSB + 4 +: 4], key};
        care = {4'hf, ~mask};
        hit  = 1'b0;
        act  = DEF_ACT;
        for (int i = 0; i < DEPTH; i++) begin
            if (!hit && cam_vld[i] && ((cam_model[i] ^ word) & care) == '0) begin
                hit = 1'b1;
                act = act_model[i];
            end
        end
    endfunction

    task automatic send_packet(input int n, input bit fwd);
        int gap;
        for (int i = 0; i < n; i++) begin
            pkt_user[i] = user_t'(rand_wide());
            pkt_keep[i] = keep_t'(rand_wide());
            if (fwd) begin
                exp_data_q.push_back(pkt_data[i]);
                exp_user_q.push_back(pkt_user[i]);
                exp_keep_q.push_back(pkt_keep[i]);
                exp_last_q.push_back(i == n - 1);
            end
        end
        for (int i = 0; i < n; i++) begin
            gap = $random(seed) & 3;
            repeat (gap) begin
                @(posedge clk);
                ctrl_in_valid <= 1'b0;
            end
            @(posedge clk);
            ctrl_in_data  <= pkt_data[i];
            ctrl_in_user  <= pkt_user[i];
            ctrl_in_keep  <= pkt_keep[i];
            ctrl_in_valid <= 1'b1;
            ctrl_in_last  <= i == n - 1;
        end
        @(posedge clk);
        ctrl_in_valid <= 1'b0;
        ctrl_in_last  <= 1'b0;
    endtask

    task automatic write_cam(input int idx, input cmp_t entry);
        beat_t sw;
        sw = beat_t'(rand_wide());
        // upper entry bits fall outside the beat
        sw[ctrl_pkg::CAM_ENTRY_LSB +: FIT_W] = entry[FIT_W-1:0];
        pkt_data[0] = beat_t'(rand_wide());
        pkt_data[1] = make_header(CLAIM_MOD, ctrl_pkg::CTRL_FLAG, 4'h0, idx);
        pkt_data[2] = byte_rev(sw);
        send_packet(3, 1'b0);
        cam_model[idx] = entry;
        cam_vld[idx]   = 1'b1;
        repeat (3) @(posedge clk);
    endtask

    task automatic write_act(input int idx, input act_t act);
        beat_t sw;
        sw = beat_t'(rand_wide());
        sw[ctrl_pkg::ACT_LO_SRC_LSB +: ctrl_pkg::ACT_MID_LSB] = act[0 +: ctrl_pkg::ACT_MID_LSB];
        pkt_data[0] = beat_t'(rand_wide());
        pkt_data[1] = make_header(CLAIM_MOD, ctrl_pkg::CTRL_FLAG, 4'(($random(seed) & 7) + 1), idx);
        pkt_data[2] = byte_rev(act[ctrl_pkg::ACT_HI_LSB +: ctrl_pkg::BEAT_W]);
        pkt_data[3] = byte_rev(act[ctrl_pkg::ACT_MID_LSB +: ctrl_pkg::BEAT_W]);
        pkt_data[4] = byte_rev(sw);
        // trailing beat goes to the drain state
        pkt_data[5] = beat_t'(rand_wide());
        send_packet(6, 1'b0);
        act_model[idx] = act;
        repeat (3) @(posedge clk);
    endtask

    task automatic send_foreign(input logic [7:0] mod, input logic [15:0] flag, input int n);
        for (int i = 0; i < n; i++) begin
            pkt_data[i] = beat_t'(rand_wide());
        end
        if (n > 1) begin
            pkt_data[1] = make_header(mod, flag, 4'($random(seed)), $random(seed) & 15);
        end
        send_packet(n, 1'b1);
    endtask

    task automatic wait_ctrl_drained();
        int waited;
        waited = 0;
        while (exp_data_q.size() != 0 && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        if (exp_data_q.size() != 0) begin
            errors++;
            $display("%0d forwarded beats never appeared on ctrl_out", exp_data_q.size());
            exp_data_q.delete();
            exp_user_q.delete();
            exp_keep_q.delete();
            exp_last_q.delete();
        end
    endtask

    task automatic do_lookup(input key_t key, input key_t mask, input phv_t phv);
        act_t e_act;
        logic e_hit;
        int   waited;
        ref_lookup(key, mask, phv, e_act, e_hit);
        exp_act_q.push_back(e_act);
        exp_phv_q.push_back(phv);
        exp_lat_q.push_back(e_hit ? 4 : 2);
        @(posedge clk);
        extract_key  <= key;
        extract_mask <= mask;
        phv_in       <= phv;
        key_valid    <= 1'b1;
        @(posedge clk);
        key_valid <= 1'b0;
        waited = 0;
        while (action_valid !== 1'b1 && waited < LOOKUP_WAIT) begin
            @(negedge clk);
            waited++;
        end
        repeat (4) @(posedge clk);
        if (exp_act_q.size() != 0) begin
            errors++;
            $display("no action_valid within %0d cycles of key_valid", LOOKUP_WAIT);
            exp_act_q.delete();
            exp_phv_q.delete();
            exp_lat_q.delete();
            start_q.delete();
        end
    endtask

    task automatic finish_test(input int num, input string name);
        int n;
        n = errors - errs_before;
        tests_run++;
        if (n != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d errors", num, name, n == 0 ? "ok" : "bad", n);
        errs_before = errors;
    endtask

    // start edge is recorded one negedge before the edge that samples key_valid
    always @(negedge clk) begin : check_lookup
        act_t e_act;
        phv_t e_phv;
        int   e_lat;
        int   st;
        ncount++;
        if (rst_n && key_valid) begin
            start_q.push_back(ncount);
        end
        if (rst_n && $isunknown(action_valid)) begin
            errors++;
            $display("action_valid is unknown at cycle %0d", ncount);
        end else if (rst_n && action_valid) begin
            if (exp_act_q.size() == 0 || start_q.size() == 0) begin
                errors++;
                $display("action_valid pulsed with no lookup pending");
            end else begin
                e_act = exp_act_q.pop_front();
                e_phv = exp_phv_q.pop_front();
                e_lat = exp_lat_q.pop_front();
                st    = start_q.pop_front();
                if (ncount - st - 1 != e_lat) begin
                    errors++;
                    $display("FAILED action_valid latency: got %h expected %h",
                             ncount - st - 1, e_lat);
                end
                if (action !== e_act) begin
                    errors++;
                    $display("FAILED action: got %h expected %h", action, e_act);
                end
                if (phv_out !== e_phv) begin
                    errors++;
                    $display("FAILED phv_out: got %h expected %h", phv_out, e_phv);
                end
            end
        end
    end

    always @(negedge clk) begin : check_ctrl
        beat_t e_data;
        user_t e_user;
        keep_t e_keep;
        logic  e_last;
        if (rst_n && ctrl_out_valid === 1'b1) begin
            if (exp_data_q.size() == 0) begin
                errors++;
                $display("unexpected beat on ctrl_out with no forwarded packet pending");
            end else begin
                e_data = exp_data_q.pop_front();
                e_user = exp_user_q.pop_front();
                e_keep = exp_keep_q.pop_front();
                e_last = exp_last_q.pop_front();
                if (ctrl_out_data !== e_data) begin
                    errors++;
                    $display("FAILED ctrl_out_data: got %h expected %h", ctrl_out_data, e_data);
                end
                if (ctrl_out_user !== e_user) begin
                    errors++;
                    $display("FAILED ctrl_out_user: got %h expected %h", ctrl_out_user, e_user);
                end
                if (ctrl_out_keep !== e_keep) begin
                    errors++;
                    $display("FAILED ctrl_out_keep: got %h expected %h", ctrl_out_keep, e_keep);
                end
                if (ctrl_out_last !== e_last) begin
                    errors++;
                    $display("FAILED ctrl_out_last: got %h expected %h", ctrl_out_last, e_last);
                end
            end
        end
    end

    initial begin : main
        key_t k;
        key_t k2;
        phv_t p;
        int   idx;
        seed          = 32'h7bba_4cf9;
        rst_n         = 1'b0;
        extract_key   = '0;
        extract_mask  = '0;
        key_valid     = 1'b0;
        phv_in        = '0;
        ctrl_in_data  = '0;
        ctrl_in_user  = '0;
        ctrl_in_keep  = '0;
        ctrl_in_valid = 1'b0;
        ctrl_in_last  = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            cam_vld[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (action_valid !== 1'b0 || ctrl_out_valid !== 1'b0 || ctrl_out_last !== 1'b0) begin
            errors++;
            $display("outputs not idle during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;

        do_lookup(key_t'(rand_wide()), '0, phv_t'(rand_wide()));
        finish_test(1, "default action after reset");

        for (int i = 0; i < 3; i++) begin
            idx = idx_list[i];
            t_key[idx] = key_t'(rand_wide());
            t_phv[idx] = with_vlan(phv_t'(rand_wide()), STORE_VLAN);
            write_cam(idx, {STORE_VLAN, t_key[idx]});
            write_act(idx, act_t'(rand_wide()));
        end
        for (int i = 0; i < 3; i++) begin
            do_lookup(t_key[idx_list[i]], '0, t_phv[idx_list[i]]);
        end
        finish_test(2, "exact hits on written entries");

        // both entries match under the mask, index 5 has priority
        k = key_t'(rand_wide());
        p = with_vlan(phv_t'(rand_wide()), STORE_VLAN);
        write_cam(9, {STORE_VLAN, k});
        write_act(9, act_t'(rand_wide()));
        write_cam(5, {STORE_VLAN, k ^ key_t'(8'hff)});
        write_act(5, act_t'(rand_wide()));
        do_lookup(k, key_t'(8'hff), p);
        do_lookup(k, '0, p);
        do_lookup(k, '1, with_vlan(p, 4'h5));
        finish_test(3, "priority and VLAN miss");

        send_foreign({5'(STAGE_ID + 1), 3'(LOOKUP_ID)}, ctrl_pkg::CTRL_FLAG, 3);
        send_foreign({5'(STAGE_ID), 3'(LOOKUP_ID + 1)}, ctrl_pkg::CTRL_FLAG, 4);
        send_foreign(CLAIM_MOD, 16'hf2f0, 2);
        send_foreign(CLAIM_MOD, ctrl_pkg::CTRL_FLAG, 1);
        wait_ctrl_drained();
        finish_test(4, "foreign packets forwarded");

        k = key_t'(rand_wide());
        p = with_vlan(phv_t'(rand_wide()), STORE_VLAN);
        write_cam(14, {STORE_VLAN, k});
        write_act(14, act_t'(rand_wide()));
        repeat (8) @(posedge clk);
        do_lookup(k, '0, p);
        finish_test(5, "claimed packets consumed");

        write_act(7, act_t'(rand_wide()));
        do_lookup(t_key[7], '0, t_phv[7]);
        k2 = key_t'(rand_wide());
        write_cam(12, {STORE_VLAN, k2});
        do_lookup(t_key[12], '0, t_phv[12]);
        do_lookup(k2, '0, t_phv[12]);
        finish_test(6, "table rewrites");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
